/* hw/control_store.sv */
// writable control store
// 4096 x 24, async read for the sequencer, sync write from the host
`timescale 1ns/1ps
`include "useq_consts.svh"

module control_store (
   input  logic                 clk4,
   input  useq_pkg::uaddr_t     uaddr,
   output useq_pkg::ucontrol_t  ucontrol,
   input  logic                 we,
   input  useq_pkg::uaddr_t     waddr,
   input  useq_pkg::ucontrol_t  wdata
);

   //////////////////////////////////////////////////
   // storage
   //////////////////////////////////////////////////

   // contents undefined until the host loads them
   useq_pkg::ucontrol_t words [0:`USEQ_CS_DEPTH-1];

   // host load port
   always_ff @(posedge clk4) begin
      if (we) begin
         words[waddr] <= wdata;
      end
   end

   // microstep read, combinational so a step is one cycle
   assign ucontrol = words[uaddr];

   // a load must carry a clean address and word from the register block
   a_load_clean : assert property (@(posedge clk4)
      we |-> !$isunknown({waddr, wdata}))
      else $error("control store load with unknown address or data");

endmodule

/* hw/microcode_sequencer.sv */
// microcode sequencer
// micro-address assembly, control word breakout, reset interlock
// holds the upc counter and the control store
`timescale 1ns/1ps
`include "useq_consts.svh"

module microcode_sequencer (
   input  logic                    clk4,
   input  logic                    reset,
   input  logic                    halt,
   input  logic                    rst_hold,
   input  useq_pkg::opcode_t       opcode,
   input  logic                    cond_in,
   input  logic [`USEQ_IDX_W-1:0]  idx,
   input  logic                    irq_ack,
   input  logic                    wait_state,
   input  logic                    end_ext,
   input  logic                    cs_we,
   input  useq_pkg::uaddr_t        cs_waddr,
   input  useq_pkg::ucontrol_t     cs_wdata,
   output useq_pkg::ureg_t         raddr,
   output useq_pkg::ureg_t         waddr,
   output logic [`USEQ_COND_W-1:0] cond,
   output useq_pkg::action_t       action,
   output logic                    mem,
   output logic                    io,
   output logic                    rd,
   output logic                    wen,
   output logic                    fetch,
   output useq_pkg::upc_t          upc,
   output useq_pkg::uaddr_t        uaddr,
   output useq_pkg::ucontrol_t     ucontrol
);

   logic uend;                        // end bit of current word
   logic upc_clear;
   logic mem_raw, io_raw, rd_raw, wen_raw;

   //////////////////////////////////////////////////
   // micro-program counter
   //////////////////////////////////////////////////

   assign upc_clear = uend | end_ext;  // either end source restarts

   upc_counter upc0 (
      .clk4       (clk4),
      .reset      (reset),
      .halt       (halt),
      .wait_state (wait_state),
      .clear      (upc_clear),
      .upc        (upc),
      .fetch      (fetch)
   );

   //////////////////////////////////////////////////
   // micro-address vector
   //////////////////////////////////////////////////

   assign uaddr = {
      rst_hold,   // 11
      irq_ack,    // 10
      opcode,     // 9..7
      cond_in,    // 6
      idx,        // 5..4
      upc         // 3..0
   };

   control_store cs0 (
      .clk4     (clk4),
      .uaddr    (uaddr),
      .ucontrol (ucontrol),
      .we       (cs_we),
      .waddr    (cs_waddr),
      .wdata    (cs_wdata)
   );

   //////////////////////////////////////////////////
   // control vector breakout
   //////////////////////////////////////////////////

   assign {
      uend,       // 23
      wen_raw,    // 22
      rd_raw,     // 21
      io_raw,     // 20
      mem_raw,    // 19
      action,     // 18..15
      cond,       // 14..10
      waddr,      // 9..5
      raddr       // 4..0
   } = ucontrol;

   // reset interlock, bus strobes off while the machine is held
   assign {wen, rd, io, mem} = rst_hold ? 4'b0000 : {wen_raw, rd_raw, io_raw, mem_raw};

endmodule

/* hw/ubus_pkg.sv */
// host bus types
// axi4-lite address, data, response and register index
`include "useq_consts.svh"

package ubus_pkg;

   typedef logic [`USEQ_AXI_AW-1:0] axi_addr_t;
   typedef logic [`USEQ_AXI_DW-1:0] axi_data_t;
   typedef logic [1:0]              axi_resp_t;

   localparam axi_resp_t RESP_OKAY = 2'b00;  // only response ever returned

   // decoded register select
   typedef enum logic [2:0] {
      REG_CTRL    = 3'd0,
      REG_LDPTR   = 3'd1,
      REG_LDDATA  = 3'd2,
      REG_STATUS  = 3'd3,
      REG_UADDR   = 3'd4,
      REG_UCTL    = 3'd5,
      REG_INVALID = 3'd7
   } reg_idx_t;

endpackage

/* hw/upc_counter.sv */
// micro-program counter
// clear beats hold, hold beats count; fetch flag decode
`timescale 1ns/1ps
`include "useq_consts.svh"

module upc_counter (
   input  logic              clk4,
   input  logic              reset,
   input  logic              halt,
   input  logic              wait_state,
   input  logic              clear,   // end bit or end_ext
   output useq_pkg::upc_t    upc,
   output logic              fetch
);

   //////////////////////////////////////////////////
   // upc register
   //////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (reset || clear) begin
         upc <= '0;                        // end of instruction
      end else if (!(halt || wait_state)) begin
         upc <= upc + 1'b1;                // wraps at 16
      end
   end

   // first microsteps fetch the next instruction
   assign fetch = (upc < useq_pkg::upc_t'(`USEQ_FETCH_STEPS));

   // halted sequencer only moves on a clear
   a_halt_holds : assert property (@(posedge clk4) disable iff (reset)
      (halt && !clear) |=> $stable(upc))
      else $error("upc moved while halted");

endmodule

/* hw/useq_consts.svh */
// microsequencer constants
// field widths, control store depth, host register map
`ifndef USEQ_CONSTS_SVH
`define USEQ_CONSTS_SVH

// microcode field widths
`define USEQ_UPC_W        4
`define USEQ_OP_W         3
`define USEQ_IDX_W        2
`define USEQ_UADDR_W      12
`define USEQ_UCTL_W       24
`define USEQ_REG_W        5
`define USEQ_COND_W       5
`define USEQ_ACT_W        4
`define USEQ_FETCH_STEPS  2     // microsteps 0 and 1 are instruction fetch
`define USEQ_CS_DEPTH     4096  // one word per micro-address

// host bus
`define USEQ_AXI_AW       8
`define USEQ_AXI_DW       32

// register byte offsets
`define USEQ_R_CTRL       8'h00
`define USEQ_R_LDPTR      8'h04
`define USEQ_R_LDDATA     8'h08
`define USEQ_R_STATUS     8'h0C
`define USEQ_R_UADDR      8'h10
`define USEQ_R_UCTL       8'h14

`endif

/* hw/useq_pkg.sv */
// microcode types
// upc, micro-address, control word and its field vectors
`include "useq_consts.svh"

package useq_pkg;

   //////////////////////////////////////////////////
   // sequencer state
   //////////////////////////////////////////////////

   typedef logic [`USEQ_UPC_W-1:0]   upc_t;     // micro-program counter
   typedef logic [`USEQ_UADDR_W-1:0] uaddr_t;   // control store index

   // micro-address, high to low:
   //   11     rst_hold
   //   10     irq_ack
   //   9..7   opcode
   //   6      cond_in
   //   5..4   idx
   //   3..0   upc

   //////////////////////////////////////////////////
   // control word
   //////////////////////////////////////////////////

   typedef logic [`USEQ_UCTL_W-1:0]  ucontrol_t;

   // control word, high to low:
   //   23     end, clears the upc
   //   22     wen
   //   21     rd
   //   20     io
   //   19     mem
   //   18..15 action
   //   14..10 cond
   //   9..5   waddr
   //   4..0   raddr

   // field vectors
   typedef logic [`USEQ_REG_W-1:0]   ureg_t;    // register file address
   typedef logic [`USEQ_ACT_W-1:0]   action_t;  // alu action code
   typedef logic [`USEQ_OP_W-1:0]    opcode_t;  // narrowed instruction field

endpackage

/* hw/useq_regs.sv */
// axi4-lite register block for the sequencer
// ctrl, load pointer, load data, status, live uaddr and ucontrol
`timescale 1ns/1ps
`include "useq_consts.svh"

module useq_regs (
   input  logic                  clk4,
   input  logic                  reset,
   // write address
   input  ubus_pkg::axi_addr_t   awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   // write data
   input  ubus_pkg::axi_data_t   wdata,
   input  logic [3:0]            wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   // write response
   output ubus_pkg::axi_resp_t   bresp,
   output logic                  bvalid,
   input  logic                  bready,
   // read address
   input  ubus_pkg::axi_addr_t   araddr,
   input  logic                  arvalid,
   output logic                  arready,
   // read data
   output ubus_pkg::axi_data_t   rdata,
   output ubus_pkg::axi_resp_t   rresp,
   output logic                  rvalid,
   input  logic                  rready,
   // sequencer side
   output logic                  halt,
   output logic                  rst_hold,
   output logic                  cs_we,
   output useq_pkg::uaddr_t      cs_waddr,
   output useq_pkg::ucontrol_t   cs_wdata,
   input  useq_pkg::upc_t        upc,
   input  logic                  fetch,
   input  useq_pkg::uaddr_t      uaddr,
   input  useq_pkg::ucontrol_t   ucontrol
);

   logic                wr_take, rd_take;
   ubus_pkg::reg_idx_t  wr_idx, rd_idx;
   useq_pkg::uaddr_t    ld_ptr;       // next store word to load
   ubus_pkg::axi_data_t rd_mux;

   function automatic ubus_pkg::reg_idx_t decode(input ubus_pkg::axi_addr_t a);
      case (a)
         `USEQ_R_CTRL:   decode = ubus_pkg::REG_CTRL;
         `USEQ_R_LDPTR:  decode = ubus_pkg::REG_LDPTR;
         `USEQ_R_LDDATA: decode = ubus_pkg::REG_LDDATA;
         `USEQ_R_STATUS: decode = ubus_pkg::REG_STATUS;
         `USEQ_R_UADDR:  decode = ubus_pkg::REG_UADDR;
         `USEQ_R_UCTL:   decode = ubus_pkg::REG_UCTL;
         default:        decode = ubus_pkg::REG_INVALID;
      endcase
   endfunction

   assign wr_idx = decode(awaddr);
   assign rd_idx = decode(araddr);

   //////////////////////////////////////////////////
   // write channel
   //////////////////////////////////////////////////

   assign wr_take = awvalid && wvalid && !bvalid;  // both halves together
   assign awready = wr_take;
   assign wready  = wr_take;
   assign bresp   = ubus_pkg::RESP_OKAY;

   always_ff @(posedge clk4) begin
      if (reset) begin
         bvalid   <= 1'b0;
         halt     <= 1'b1;                 // come up stopped and held
         rst_hold <= 1'b1;
         ld_ptr   <= '0;
      end else begin
         if (wr_take) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end
         if (wr_take && wr_idx == ubus_pkg::REG_CTRL && wstrb[0]) begin
            {rst_hold, halt} <= wdata[1:0];
         end
         if (wr_take && wr_idx == ubus_pkg::REG_LDPTR) begin
            if (wstrb[0]) ld_ptr[7:0]  <= wdata[7:0];
            if (wstrb[1]) ld_ptr[11:8] <= wdata[11:8];
         end else if (cs_we) begin
            ld_ptr <= ld_ptr + 1'b1;       // auto-increment after each word
         end
      end
   end

   // store load straight from the handshake cycle, whole word always
   assign cs_we    = wr_take && (wr_idx == ubus_pkg::REG_LDDATA);
   assign cs_waddr = ld_ptr;
   assign cs_wdata = wdata[`USEQ_UCTL_W-1:0];

   //////////////////////////////////////////////////
   // read channel
   //////////////////////////////////////////////////

   assign rd_take = arvalid && !rvalid;
   assign arready = rd_take;
   assign rresp   = ubus_pkg::RESP_OKAY;

   always_comb begin
      case (rd_idx)
         ubus_pkg::REG_CTRL:   rd_mux = {30'b0, rst_hold, halt};
         ubus_pkg::REG_LDPTR:  rd_mux = ubus_pkg::axi_data_t'(ld_ptr);
         ubus_pkg::REG_STATUS: rd_mux = {22'b0, rst_hold, halt, 3'b0, fetch, upc};
         ubus_pkg::REG_UADDR:  rd_mux = ubus_pkg::axi_data_t'(uaddr);     // live
         ubus_pkg::REG_UCTL:   rd_mux = ubus_pkg::axi_data_t'(ucontrol);  // live
         default:              rd_mux = '0;  // ldata is write only
      endcase
   end

   always_ff @(posedge clk4) begin
      if (reset) begin
         rvalid <= 1'b0;
      end else if (rd_take) begin
         rvalid <= 1'b1;
      end else if (rready) begin
         rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk4) begin
      if (rd_take) begin
         rdata <= rd_mux;                  // sampled at acceptance
      end
   end

   // response held under back-pressure
   a_bvalid_hold : assert property (@(posedge clk4) disable iff (reset)
      (bvalid && !bready) |=> bvalid)
      else $error("bvalid dropped before bready");

endmodule

/* hw/useq_top.sv */
// sequencer subsystem top
// axi4-lite register block beside the microcode sequencer
`timescale 1ns/1ps
`include "useq_consts.svh"

module useq_top (
   input  logic                    clk4,
   input  logic                    reset,
   // host
   input  ubus_pkg::axi_addr_t     awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  ubus_pkg::axi_data_t     wdata,
   input  logic [3:0]              wstrb,
   input  logic                    wvalid,
   output logic                    wready,
   output ubus_pkg::axi_resp_t     bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  ubus_pkg::axi_addr_t     araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output ubus_pkg::axi_data_t     rdata,
   output ubus_pkg::axi_resp_t     rresp,
   output logic                    rvalid,
   input  logic                    rready,
   // machine inputs
   input  useq_pkg::opcode_t       opcode,
   input  logic                    cond_in,
   input  logic [`USEQ_IDX_W-1:0]  idx,
   input  logic                    irq_ack,
   input  logic                    wait_state,
   input  logic                    end_ext,
   // machine outputs
   output useq_pkg::ureg_t         raddr,
   output useq_pkg::ureg_t         waddr,
   output logic [`USEQ_COND_W-1:0] cond,
   output useq_pkg::action_t       action,
   output logic                    mem,
   output logic                    io,
   output logic                    rd,
   output logic                    wen,
   output logic                    fetch
);

   logic                halt, rst_hold;
   logic                cs_we;
   useq_pkg::uaddr_t    cs_waddr;
   useq_pkg::ucontrol_t cs_wdata;
   useq_pkg::upc_t      upc;
   useq_pkg::uaddr_t    uaddr;     // live view back to the host
   useq_pkg::ucontrol_t ucontrol;

   useq_regs regs0 (
      .clk4 (clk4), .reset (reset),
      .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
      .bresp (bresp), .bvalid (bvalid), .bready (bready),
      .araddr (araddr), .arvalid (arvalid), .arready (arready),
      .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
      .halt (halt), .rst_hold (rst_hold),
      .cs_we (cs_we), .cs_waddr (cs_waddr), .cs_wdata (cs_wdata),
      .upc (upc), .fetch (fetch), .uaddr (uaddr), .ucontrol (ucontrol)
   );

   microcode_sequencer seq0 (
      .clk4 (clk4), .reset (reset),
      .halt (halt), .rst_hold (rst_hold),
      .opcode (opcode), .cond_in (cond_in), .idx (idx), .irq_ack (irq_ack),
      .wait_state (wait_state), .end_ext (end_ext),
      .cs_we (cs_we), .cs_waddr (cs_waddr), .cs_wdata (cs_wdata),
      .raddr (raddr), .waddr (waddr), .cond (cond), .action (action),
      .mem (mem), .io (io), .rd (rd), .wen (wen), .fetch (fetch),
      .upc (upc), .uaddr (uaddr), .ucontrol (ucontrol)
   );

endmodule

/* tb.f */
+incdir+hw
+incdir+tb
hw/useq_pkg.sv
hw/ubus_pkg.sv
hw/upc_counter.sv
hw/control_store.sv
hw/microcode_sequencer.sv
hw/useq_regs.sv
hw/useq_top.sv
tb/useq_tb.sv

/* tb/useq_tb_axi.svh */
// host side helpers for the sequencer testbench
// axi4-lite single write and single read, xorshift step
`ifndef USEQ_TB_AXI_SVH
`define USEQ_TB_AXI_SVH

   //////////////////////////////////////////////////
   // axi4-lite host
   //////////////////////////////////////////////////

   // address and data offered together, response drained
   task automatic axi_write(input ubus_pkg::axi_addr_t addr, input ubus_pkg::axi_data_t data);
      @(negedge clk4);
      awaddr  = addr;
      wdata   = data;
      wstrb   = 4'hf;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      bready  = 1'b1;
      do begin
         @(posedge clk4);
      end while (!(awready && wready));    // handshake edge
      @(negedge clk4);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      do begin
         @(posedge clk4);
      end while (!bvalid);
      check_resp("bresp", bresp, ubus_pkg::RESP_OKAY);
   endtask

   task automatic axi_read(input ubus_pkg::axi_addr_t addr, output ubus_pkg::axi_data_t data);
      @(negedge clk4);
      araddr  = addr;
      arvalid = 1'b1;
      rready  = 1'b1;
      do begin
         @(posedge clk4);
      end while (!arready);
      @(negedge clk4);
      arvalid = 1'b0;
      do begin
         @(posedge clk4);
      end while (!rvalid);                 // data held since acceptance
      data = rdata;
      check_resp("rresp", rresp, ubus_pkg::RESP_OKAY);
   endtask

   // xorshift32, shifts 13 17 5
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

`endif

/* tb/useq_tb.sv */
// testbench for the microcode sequencer subsystem
// clock, reset, image load, stimulus table, reference model, checks, watchdog
`timescale 1ns/1ps
`include "useq_consts.svh"

module useq_tb;

   logic                    clk4 = 1'b0;
   logic                    reset;
   ubus_pkg::axi_addr_t     awaddr, araddr;
   ubus_pkg::axi_data_t     wdata, rdata;
   logic [3:0]              wstrb;
   logic                    awvalid, awready, wvalid, wready, bvalid, bready;
   logic                    arvalid, arready, rvalid, rready;
   ubus_pkg::axi_resp_t     bresp, rresp;
   useq_pkg::opcode_t       opcode;
   logic                    cond_in, irq_ack, wait_state, end_ext;
   logic [`USEQ_IDX_W-1:0]  idx;
   useq_pkg::ureg_t         raddr, waddr;
   logic [`USEQ_COND_W-1:0] cond;
   useq_pkg::action_t       action;
   logic                    mem, io, rd, wen, fetch;

   useq_pkg::ucontrol_t image [0:`USEQ_CS_DEPTH-1];  // model of the store
   logic [16:0]         rows [$];       // {op, cond, idx, irq, wait, end, cycles}
   int                  hold_row;       // first row run under reset hold
   int                  total_cycles = 0;
   int                  n_checks = 0;
   int                  n_errors = 0;
   logic [31:0]         rng;

   useq_top dut0 (.*);

   always #50 clk4 = ~clk4;             // 100 ns period

   `include "useq_tb_axi.svh"

   //////////////////////////////////////////////////
   // compare tasks
   //////////////////////////////////////////////////

   task automatic compare_value(input string name, input logic [31:0] act, want);
      n_checks++;
      if (act !== want) begin
         n_errors++;
         $display("error at %0t ns: %s is %0h, expected %0h", $time, name, act, want);
      end
   endtask

   task automatic check_upc(input string name, input useq_pkg::upc_t act, want);
      compare_value(name, 32'(act), 32'(want));
   endtask
   task automatic check_ureg(input string name, input useq_pkg::ureg_t act, want);
      compare_value(name, 32'(act), 32'(want));
   endtask
   task automatic check_action(input string name, input useq_pkg::action_t act, want);
      compare_value(name, 32'(act), 32'(want));
   endtask
   task automatic check_bit(input string name, input logic act, want);
      compare_value(name, 32'(act), 32'(want));
   endtask
   task automatic check_word(input string name, input useq_pkg::ucontrol_t act, want);
      compare_value(name, 32'(act), 32'(want));
   endtask
   task automatic check_resp(input string name, input ubus_pkg::axi_resp_t act, want);
      compare_value(name, 32'(act), 32'(want));
   endtask

   //////////////////////////////////////////////////
   // stimulus table and model helpers
   //////////////////////////////////////////////////

   task automatic add_row(input useq_pkg::opcode_t op, input logic c, input logic [1:0] ix,
                          input logic irq, wt, ex, input logic [7:0] n);
      rows.push_back({op, c, ix, irq, wt, ex, n});
      total_cycles += n;
   endtask

   task automatic drive_row(input logic [16:0] r);
      opcode     = r[16:14];
      cond_in    = r[13];
      idx        = r[12:11];
      irq_ack    = r[10];
      wait_state = r[9];
      end_ext    = r[8];
   endtask

   // micro-address rule, hold high down to upc low
   function automatic useq_pkg::uaddr_t exp_uaddr(input logic hold, input logic [16:0] r,
                                                  input useq_pkg::upc_t u);
      return {hold, r[10], r[16:14], r[13], r[12:11], u};
   endfunction

   initial begin
      ubus_pkg::axi_data_t rdv;
      useq_pkg::ucontrol_t w;
      useq_pkg::upc_t      mupc;          // model upc
      logic                hold;
      logic [16:0]         r;

      reset      = 1'b1;
      awaddr     = '0;
      awvalid    = 1'b0;
      wdata      = '0;
      wstrb      = '0;
      wvalid     = 1'b0;
      bready     = 1'b0;
      araddr     = '0;
      arvalid    = 1'b0;
      rready     = 1'b0;
      drive_row('0);

      //       op  c  idx irq wt ex  n
      add_row(0, 0, 0, 0, 0, 0, 12);    // four step program, wraps three times
      add_row(5, 1, 2, 0, 0, 0, 20);
      add_row(2, 0, 1, 1, 1, 0, 3);     // wait holds upc
      add_row(2, 0, 1, 1, 0, 0, 2);
      add_row(7, 1, 3, 0, 0, 0, 6);
      add_row(7, 1, 3, 0, 0, 1, 1);     // end_ext pulse
      add_row(7, 1, 3, 0, 0, 0, 14);
      add_row(3, 0, 0, 1, 0, 0, 10);
      hold_row = rows.size();
      add_row(4, 1, 1, 0, 0, 0, 10);    // rst_hold set from here on
      add_row(6, 0, 2, 1, 1, 0, 3);
      add_row(6, 0, 2, 1, 0, 0, 12);
      add_row(1, 1, 0, 0, 0, 1, 1);
      add_row(1, 1, 0, 0, 0, 0, 8);

      // random image, end bit exactly at upc == opcode + 3
      rng = 32'he630_c041;
      for (int i = 0; i < `USEQ_CS_DEPTH; i++) begin
         rng = xorshift(rng);
         w = rng[23:0];
         w[23] = (i[3:0] == {1'b0, i[9:7]} + 4'd3);
         image[i] = w;
      end

      repeat (8) @(posedge clk4);
      @(negedge clk4);
      reset = 1'b0;

      // state straight out of reset
      axi_read(`USEQ_R_STATUS, rdv);
      check_upc("status upc", rdv[3:0], 4'd0);
      check_bit("status fetch", rdv[4], 1'b1);
      check_bit("status halt", rdv[8], 1'b1);
      check_bit("status rst_hold", rdv[9], 1'b1);
      check_bit("mem", mem, 1'b0);
      check_bit("io", io, 1'b0);
      check_bit("rd", rd, 1'b0);
      check_bit("wen", wen, 1'b0);

      axi_write(`USEQ_R_LDPTR, 32'd0);
      for (int i = 0; i < `USEQ_CS_DEPTH; i++) begin
         axi_write(`USEQ_R_LDDATA, 32'(image[i]));
      end

      // halted readback of the live word, upc parked at 0
      foreach (rows[i]) begin
         @(negedge clk4);
         drive_row(rows[i]);
         axi_read(`USEQ_R_UCTL, rdv);
         check_word("uctl readback", rdv[23:0], image[exp_uaddr(1'b1, rows[i], 4'd0)]);
      end

      ////////////////////////////////////////////////// run the table
      @(negedge clk4);
      end_ext = 1'b1;                   // pin upc at 0 across the start
      axi_write(`USEQ_R_CTRL, 32'd0);
      mupc = '0;
      hold = 1'b0;
      foreach (rows[i]) begin
         r = rows[i];
         if (i == hold_row) begin
            @(negedge clk4);
            end_ext = 1'b1;
            axi_write(`USEQ_R_CTRL, 32'd2);   // rst_hold on, still running
            mupc = '0;
            hold = 1'b1;
         end
         for (int c = 0; c < r[7:0]; c++) begin
            @(negedge clk4);
            drive_row(r);
            @(posedge clk4);              // pre-edge values, stable since negedge
            w = image[exp_uaddr(hold, r, mupc)];
            check_upc("upc", dut0.upc, mupc);
            check_word("ucontrol", dut0.ucontrol, w);
            check_ureg("raddr", raddr, w[4:0]);
            check_ureg("waddr", waddr, w[9:5]);
            check_ureg("cond", cond, w[14:10]);
            check_action("action", action, w[18:15]);
            check_bit("mem", mem, w[19] & ~hold);
            check_bit("io", io, w[20] & ~hold);
            check_bit("rd", rd, w[21] & ~hold);
            check_bit("wen", wen, w[22] & ~hold);
            check_bit("fetch", fetch, mupc < 4'd2);
            if (w[23] || r[8]) begin
               mupc = '0;                 // end bit or end_ext
            end else if (!r[9]) begin
               mupc = mupc + 1'b1;
            end
         end
      end

      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // watchdog, table + load + margin
   initial begin
      #1;
      repeat (total_cycles + 4 * `USEQ_CS_DEPTH + 500) @(posedge clk4);
      $display("timeout: the run did not finish in time, %0d errors so far", n_errors);
      $display("Testbench failed");
      $finish;
   end

endmodule
